// ==== tb.f ====
+incdir+bench
common/mac_pkg.sv
common/stage_ctrl_if.sv
source/adder_tree.sv
source/mac_pe.sv
mac_array/mac_channel.sv
mac_array/mac_array.sv
bench/mac_array_tb.sv

// ==== Bender.yml ====
package:
  name: mac_array

sources:
  # shared package and interface
  - common/mac_pkg.sv
  - common/stage_ctrl_if.sv
  # design
  - source/adder_tree.sv
  - source/mac_pe.sv
  - mac_array/mac_channel.sv
  - mac_array/mac_array.sv
  # testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mac_array_tb.sv

// ==== bench/mac_model.svh ====
// reference model of the MAC array: lane products, the full dot product
// and the five-deep queue of sums waiting for the bias edge
`ifndef MAC_MODEL_SVH
`define MAC_MODEL_SVH

typedef logic [pe_count*lanes*data_w-1:0] op_vec_t;

word_t sum_queue [5]; // PE, two channel levels, two cross-channel levels
word_t expected_dot = '0;

// full signed product, arithmetic shift, keep the low word
function automatic word_t ref_product(input word_t a, input word_t b);
    longint full;

    full = longint'(a) * longint'(b);
    full = full >>> frac_w;
    return word_t'(full[data_w-1:0]);
endfunction

function automatic word_t ref_dot(input op_vec_t act [channel_count],
                                  input op_vec_t wt [channel_count]);
    word_t total;
    word_t a;
    word_t w;

    total = '0;
    for (int c = 0; c < channel_count; c++) begin
        for (int i = 0; i < pe_count * lanes; i++) begin
            a = act[c][i*data_w +: data_w];
            w = wt[c][i*data_w +: data_w];
            total = total + ref_product(a, w); // wraps mod 2^16
        end
    end
    return total;
endfunction

// one clock edge of the expected pipeline
task automatic model_step(input logic rst_v, input logic clr_v, input logic en_v,
                          input word_t bias_v, input word_t new_sum);
    if (rst_v || clr_v) begin
        foreach (sum_queue[i]) sum_queue[i] = '0;
        expected_dot = '0;
    end else if (en_v) begin
        expected_dot = sum_queue[4] + bias_v;
        for (int i = 4; i > 0; i--) begin
            sum_queue[i] = sum_queue[i-1];
        end
        sum_queue[0] = new_sum;
    end
endtask

`endif

// ==== bench/mac_array_tb.sv ====
// testbench for the MAC array: random and corner operands,
// stalls, clear and bias timing, checked against a model
module mac_array_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mac_pkg::*;

    `include "mac_model.svh"

    //////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////

    localparam int reset_cycles  = 10;
    localparam int total_cycles  = reset_cycles + 6 + 48 + 60 + 27 + 16 + 24 + 10;
    localparam int timeout_limit = 3 * total_cycles + 100;

    logic    clk = 1'b0;
    logic    rst;
    logic    en;
    logic    clr;
    word_t   bias;
    word_t   dot_product;
    op_vec_t activations [channel_count];
    op_vec_t weights     [channel_count];

    logic [31:0] lcg_state = 32'd22098;
    int          cycle_count = 0;
    int          checks_done = 0;
    int          errors = 0;
    word_t       steady_bias;

    mac_array #(
        .channel_count (channel_count),
        .pe_count      (pe_count),
        .frac_w        (frac_w)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .clr         (clr),
        .activations (activations),
        .weights     (weights),
        .bias        (bias),
        .dot_product (dot_product)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t rand_word();
        logic [31:0] r;

        r = lcg_next();
        return word_t'(r[31:16]); // upper half of the state
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks_done++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // next rising edge, then new control levels
    task automatic apply(input logic en_v, input logic clr_v, input word_t bias_v);
        @(posedge clk);
        en   <= en_v;
        clr  <= clr_v;
        bias <= bias_v;
    endtask

    task automatic fill_random();
        op_vec_t a_vec;
        op_vec_t w_vec;

        for (int c = 0; c < channel_count; c++) begin
            for (int i = 0; i < pe_count * lanes; i++) begin
                a_vec[i*data_w +: data_w] = rand_word();
                w_vec[i*data_w +: data_w] = rand_word();
            end
            activations[c] <= a_vec;
            weights[c]     <= w_vec;
        end
    endtask

    task automatic fill_corner(input int kind);
        op_vec_t a_vec;
        op_vec_t w_vec;
        word_t   a;
        word_t   w;

        for (int i = 0; i < pe_count * lanes; i++) begin
            case (kind)
                0: begin // largest positive
                    a = 16'h7fff;
                    w = 16'h7fff;
                end
                1: begin // most negative
                    a = 16'h8000;
                    w = 16'h8000;
                end
                2: begin
                    a = (i % 2 != 0) ? 16'h8000 : 16'h7fff;
                    w = (i % 3 == 0) ? 16'h8000 : 16'h7fff;
                end
                default: begin // below one fractional lsb
                    a = 16'h0001;
                    w = (i % 2 != 0) ? 16'hffff : 16'h0001;
                end
            endcase
            a_vec[i*data_w +: data_w] = a;
            w_vec[i*data_w +: data_w] = w;
        end
        for (int c = 0; c < channel_count; c++) begin
            activations[c] <= a_vec;
            weights[c]     <= w_vec;
        end
    endtask

    //////////////////////////////////////////////////
    // model, checker and timeout
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        model_step(rst, clr, en, bias, ref_dot(activations, weights));
    end

    always @(negedge clk) begin
        if (cycle_count > 0) check_value("dot_product", dot_product, expected_dot);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        rst  <= 1'b1;
        en   <= 1'b0;
        clr  <= 1'b0;
        bias <= '0;
        foreach (activations[c]) activations[c] <= '0;
        foreach (weights[c]) weights[c] <= '0;
        steady_bias = rand_word();

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // idle with en low, output stays zero
        repeat (6) begin
            apply(1'b0, 1'b0, rand_word());
            fill_random();
            @(negedge clk);
            check_value("dot_product", dot_product, '0);
        end

        repeat (48) begin
            apply(1'b1, 1'b0, steady_bias);
            fill_random();
        end

        // en low about a third of the time
        repeat (60) begin
            apply((lcg_next() % 3) != 0, 1'b0, steady_bias);
            fill_random();
        end

        // clear in mid-stream
        repeat (10) begin
            apply(1'b1, 1'b0, steady_bias);
            fill_random();
        end
        apply(1'b1, 1'b1, steady_bias);
        fill_random();
        apply(1'b1, 1'b0, steady_bias); // edge that sees clr
        fill_random();
        @(negedge clk);
        check_value("dot_product", dot_product, '0);
        repeat (5) begin
            apply(1'b1, 1'b0, steady_bias);
            fill_random();
            @(negedge clk);
            check_value("dot_product", dot_product, steady_bias);
        end
        repeat (10) begin
            apply(1'b1, 1'b0, steady_bias);
            fill_random();
        end

        for (int kind = 0; kind < 4; kind++) begin
            repeat (4) begin
                apply(1'b1, 1'b0, steady_bias);
                fill_corner(kind);
            end
        end

        // new bias every cycle
        repeat (24) begin
            apply(1'b1, 1'b0, rand_word());
            fill_random();
        end

        repeat (10) apply(1'b1, 1'b0, steady_bias);
        @(negedge clk);

        $display("checks %0d, errors %0d", checks_done, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mac_array/mac_array.sv ====
// MAC array top: channels, cross-channel adder tree and bias register
// six enabled edges from operands to dot_product
module mac_array #(
    parameter int unsigned channel_count = mac_pkg::channel_count,
    parameter int unsigned pe_count      = mac_pkg::pe_count,
    parameter int unsigned frac_w        = mac_pkg::frac_w
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic clr,

    // one flat vector per channel, lane 0 in the low bits
    input  logic [pe_count*mac_pkg::lanes*mac_pkg::data_w-1:0] activations [channel_count],
    input  logic [pe_count*mac_pkg::lanes*mac_pkg::data_w-1:0] weights     [channel_count],

    input  mac_pkg::word_t bias,
    output mac_pkg::word_t dot_product
);

    import mac_pkg::*;

    stage_ctrl_if ctrl ();

    word_t channel_sums [channel_count];
    word_t tree_sum;

    assign ctrl.clk = clk;
    assign ctrl.rst = rst;
    assign ctrl.en  = en;
    assign ctrl.clr = clr;

    //////////////////////////////////////////////////
    // channels
    //////////////////////////////////////////////////

    for (genvar c = 0; c < channel_count; c++) begin : g_channel
        mac_channel #(
            .pe_count (pe_count),
            .frac_w   (frac_w)
        ) u_channel (
            .ctrl        (ctrl.stage),
            .activations (activations[c]),
            .weights     (weights[c]),
            .channel_sum (channel_sums[c])
        );
    end

    //////////////////////////////////////////////////
    // cross-channel reduction and bias
    //////////////////////////////////////////////////

    adder_tree #(
        .inputs (channel_count)
    ) u_channel_tree (
        .ctrl     (ctrl.stage),
        .operands (channel_sums),
        .sum      (tree_sum)
    );

    // bias taken at the last edge, not when operands entered
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            dot_product <= '0;
        end else if (en) begin
            dot_product <= tree_sum + bias; // wraps mod 2^16
        end
    end

endmodule

// ==== mac_array/mac_channel.sv ====
// one input channel: pe_count PEs of eight lanes each
// and the tree that sums their outputs
module mac_channel #(
    parameter int unsigned pe_count = mac_pkg::pe_count,
    parameter int unsigned frac_w   = mac_pkg::frac_w
) (
    stage_ctrl_if.stage ctrl,

    input  logic [pe_count*mac_pkg::lanes*mac_pkg::data_w-1:0] activations,
    input  logic [pe_count*mac_pkg::lanes*mac_pkg::data_w-1:0] weights,

    output mac_pkg::word_t channel_sum
);

    import mac_pkg::*;

    word_t pe_act    [pe_count][lanes];
    word_t pe_weight [pe_count][lanes];
    word_t pe_sums   [pe_count];

    //////////////////////////////////////////////////
    // slice operands into per-PE lane groups
    //////////////////////////////////////////////////

    for (genvar p = 0; p < pe_count; p++) begin : g_pe
        for (genvar l = 0; l < lanes; l++) begin : g_lane
            localparam int unsigned base = (p * lanes + l) * data_w;

            assign pe_act[p][l]    = word_t'(activations[base +: data_w]);
            assign pe_weight[p][l] = word_t'(weights[base +: data_w]);
        end

        mac_pe #(
            .frac_w (frac_w)
        ) u_pe (
            .ctrl        (ctrl),
            .activations (pe_act[p]),
            .weights     (pe_weight[p]),
            .pe_sum      (pe_sums[p])
        );
    end

    // two levels for four PEs
    adder_tree #(
        .inputs (pe_count)
    ) u_pe_tree (
        .ctrl     (ctrl),
        .operands (pe_sums),
        .sum      (channel_sum)
    );

endmodule

// ==== source/mac_pe.sv ====
// processing element: eight fixed-point lane products
// summed with wrap and registered once
module mac_pe #(
    parameter int unsigned frac_w = mac_pkg::frac_w
) (
    stage_ctrl_if.stage ctrl,

    input  mac_pkg::word_t activations [mac_pkg::lanes],
    input  mac_pkg::word_t weights     [mac_pkg::lanes],

    output mac_pkg::word_t pe_sum
);

    import mac_pkg::*;

    word_t products [lanes];
    word_t lane_sum;
    word_t sum_q;

    //////////////////////////////////////////////////
    // lane multiplies
    //////////////////////////////////////////////////

    for (genvar l = 0; l < lanes; l++) begin : g_mul
        assign products[l] = fx_mul(activations[l], weights[l], frac_w);
    end

    // sum over all lanes
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < lanes; l++) begin
            lane_sum = lane_sum + products[l]; // wraps mod 2^16
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge ctrl.clk) begin
        if (ctrl.rst || ctrl.clr) begin
            sum_q <= '0;
        end else if (ctrl.en) begin
            sum_q <= lane_sum;
        end
    end

    assign pe_sum = sum_q;

endmodule

// ==== source/adder_tree.sv ====
// pairwise adder tree, one register per level
// latency is log2(inputs), a single stage for one input
module adder_tree #(
    parameter int unsigned inputs = 4 // power of two
) (
    stage_ctrl_if.stage ctrl,

    input  mac_pkg::word_t operands [inputs],
    output mac_pkg::word_t sum
);

    import mac_pkg::*;

    if (inputs == 1) begin : g_single
        word_t sum_q;

        always_ff @(posedge ctrl.clk) begin
            if (ctrl.rst || ctrl.clr) begin
                sum_q <= '0;
            end else if (ctrl.en) begin
                sum_q <= operands[0];
            end
        end

        assign sum = sum_q;
    end else begin : g_tree
        // node n has children 2n and 2n+1 in heap order
        // and positions inputs and up are the operands themselves
        word_t node_q [1:inputs-1];

        for (genvar n = 1; n < inputs; n++) begin : g_node
            word_t left;
            word_t right;

            if (2 * n >= inputs) begin : g_leaf
                assign left  = operands[2*n - inputs];
                assign right = operands[2*n + 1 - inputs];
            end else begin : g_inner
                assign left  = node_q[2*n];
                assign right = node_q[2*n + 1];
            end

            always_ff @(posedge ctrl.clk) begin
                if (ctrl.rst || ctrl.clr) begin
                    node_q[n] <= '0;
                end else if (ctrl.en) begin
                    node_q[n] <= left + right; // wraps
                end
            end
        end

        assign sum = node_q[1]; // root
    end

endmodule

// ==== common/stage_ctrl_if.sv ====
// pipeline stage control: clock, reset, enable and clear
// shared by every register stage of the MAC array
interface stage_ctrl_if;

    logic clk;
    logic rst; // sync, active high
    logic en;  // advance on enabled edges only
    logic clr; // flush, wins over en

    // seen by every stage register
    modport stage (
        input clk,
        input rst,
        input en,
        input clr
    );

endinterface

// ==== common/mac_pkg.sv ====
// shared sizes, word types and fixed-point multiply
// for the dense-layer MAC array
package mac_pkg;

    //////////////////////////////////////////////////
    // array sizes
    //////////////////////////////////////////////////

    localparam int unsigned data_w        = 16; // Q8.8 word
    localparam int unsigned frac_w        = 8;
    localparam int unsigned lanes         = 8;  // multiplies per PE
    localparam int unsigned pe_count      = 4;  // PEs per channel
    localparam int unsigned channel_count = 4;

    //////////////////////////////////////////////////
    // word types
    //////////////////////////////////////////////////

    // activations, weights, partial sums, bias and result
    typedef logic signed [data_w-1:0] word_t;

    // full product before the shift
    typedef logic signed [2*data_w-1:0] prod_t;

    //////////////////////////////////////////////////
    // arithmetic
    //////////////////////////////////////////////////

    // signed product, arithmetic shift by the fraction width,
    // then truncation back to one word
    function automatic word_t fx_mul(
        input word_t       a,
        input word_t       b,
        input int unsigned shift = frac_w
    );
        prod_t full;
        prod_t shifted;

        full    = prod_t'(a) * prod_t'(b);
        shifted = full >>> shift; // keeps the sign
        return word_t'(shifted); // upper bits dropped, wraps
    endfunction

endpackage
